/* verilog/axi_mem_pkg.sv */
package axi_mem_pkg;

    localparam int ADDR_WIDTH = 32;              // byte address
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;  // one strobe per byte lane
    localparam int ID_WIDTH = 2;
    localparam int WAIT_WIDTH = 4;               // memory response wait states, 0..15
    localparam int LIMIT_WIDTH = 16;             // stall limit and request count

    // address channel, shared by AR and AW
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [2:0]            size;  // log2 of bytes per beat
    } axi_addr_t;

    // write data channel
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;  // always set, single beat
    } axi_w_t;

    // read response channel, resp field omitted since every response is OKAY
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
    } axi_r_t;

    // write response channel
    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
    } axi_b_t;

endpackage

/* verilog/set_clr_reg.sv */
`timescale 1ns/1ps

// one-bit flag, set and clear take effect on the next edge
module set_clr_reg #(
    parameter bit SET_OVER_CLR = 1'b0,  // winner when set and clr collide
    parameter bit RST_VALUE = 1'b0
) (
    input  logic clk,
    input  logic rst,
    input  logic set,
    input  logic clr,
    output logic result
);

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= RST_VALUE;
        end else if (SET_OVER_CLR) begin
            result <= set | (result & ~clr);  // set wins
        end else begin
            result <= (set | result) & ~clr;  // clr wins
        end
    end

endmodule

/* verilog/axi_master.sv */
`timescale 1ns/1ps

// single-beat AXI master, one transaction outstanding
module axi_master #(
    parameter int ID = 1
) (
    input  logic clk,
    input  logic rst,

    // request port
    input  logic                               new_request,  // strobe, only while ready_out
    input  logic                               we,
    input  logic [axi_mem_pkg::ADDR_WIDTH-1:0] addr,
    input  logic [2:0]                         size,
    input  logic [axi_mem_pkg::DATA_WIDTH-1:0] data_in,
    input  logic [axi_mem_pkg::STRB_WIDTH-1:0] wstrb,
    output logic                               ready_out,
    output logic                               valid_out,    // one-cycle read completion
    output logic [axi_mem_pkg::DATA_WIDTH-1:0] data_out,

    // AXI channels
    output axi_mem_pkg::axi_addr_t ar,
    output logic                   arvalid,
    input  logic                   arready,
    output axi_mem_pkg::axi_addr_t aw,
    output logic                   awvalid,
    input  logic                   awready,
    output axi_mem_pkg::axi_w_t    w,
    output logic                   wvalid,
    input  logic                   wready,
    input  axi_mem_pkg::axi_r_t    r,        // rready tied high
    input  logic                   rvalid,
    input  axi_mem_pkg::axi_b_t    b,        // bready tied high
    input  logic                   bvalid,

    // watchdog
    input  logic [axi_mem_pkg::LIMIT_WIDTH-1:0] stall_limit,
    output logic                                stall
);
    localparam logic [axi_mem_pkg::ID_WIDTH-1:0] MY_ID = ID[axi_mem_pkg::ID_WIDTH-1:0];

    axi_mem_pkg::axi_addr_t                req_q;       // same address payload for AR and AW
    logic [axi_mem_pkg::DATA_WIDTH-1:0]    wdata_q;
    logic [axi_mem_pkg::STRB_WIDTH-1:0]    wstrb_q;
    logic                                  r_hit;       // read response for this master
    logic                                  b_hit;
    logic [axi_mem_pkg::LIMIT_WIDTH-1:0]   stall_cnt;

    // payload capture, no reset needed
    always_ff @(posedge clk) begin
        if (new_request) begin
            req_q.id <= MY_ID;
            req_q.addr <= addr;
            req_q.size <= size;
            wdata_q <= data_in;
            wstrb_q <= wstrb;
        end
    end

    assign ar = req_q;
    assign aw = req_q;
    assign w = '{data: wdata_q, strb: wstrb_q, last: wvalid};

    assign r_hit = rvalid & (r.id == MY_ID);
    assign b_hit = bvalid & (b.id == MY_ID);

    // idle flag, a response to our ID ends the transaction
    set_clr_reg #(.SET_OVER_CLR(1'b0), .RST_VALUE(1'b1)) ready_m (
        .clk,
        .rst,
        .set    (r_hit | b_hit),
        .clr    (new_request),
        .result (ready_out)
    );

    set_clr_reg #(.SET_OVER_CLR(1'b1), .RST_VALUE(1'b0)) arvalid_m (
        .clk,
        .rst,
        .set    (new_request & ~we),
        .clr    (arready),           // drops on the transfer edge
        .result (arvalid)
    );

    // AW and W raised together, the memory takes both on one edge
    set_clr_reg #(.SET_OVER_CLR(1'b1), .RST_VALUE(1'b0)) awvalid_m (
        .clk,
        .rst,
        .set    (new_request & we),
        .clr    (awready),
        .result (awvalid)
    );

    set_clr_reg #(.SET_OVER_CLR(1'b1), .RST_VALUE(1'b0)) wvalid_m (
        .clk,
        .rst,
        .set    (new_request & we),
        .clr    (wready),
        .result (wvalid)
    );

    always_ff @(posedge clk) begin
        if (rst) valid_out <= 1'b0;
        else valid_out <= r_hit;     // pulse on the completing edge
    end

    always_ff @(posedge clk) begin
        if (r_hit) data_out <= r.data;
    end

    // busy cycle counter, saturates rather than wrapping
    always_ff @(posedge clk) begin
        if (rst | ready_out) begin
            stall_cnt <= '0;
        end else if (stall_cnt != '1) begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    assign stall = stall_cnt > stall_limit;  // high every cycle past the limit

    // requester must honour the handshake
    a_req_when_ready: assert property (@(posedge clk) disable iff (rst)
        new_request |-> ready_out);

endmodule

/* verilog/axi_mem.sv */
`timescale 1ns/1ps

// AXI slave memory, one access at a time, response delayed by wait_states
module axi_mem #(
    parameter int DEPTH = 256  // words, power of two
) (
    input  logic clk,
    input  logic rst,

    input  axi_mem_pkg::axi_addr_t ar,
    input  logic                   arvalid,
    output logic                   arready,
    input  axi_mem_pkg::axi_addr_t aw,
    input  logic                   awvalid,
    output logic                   awready,
    input  axi_mem_pkg::axi_w_t    w,
    input  logic                   wvalid,
    output logic                   wready,
    output axi_mem_pkg::axi_r_t    r,
    output logic                   rvalid,
    output axi_mem_pkg::axi_b_t    b,
    output logic                   bvalid,

    input  logic [axi_mem_pkg::WAIT_WIDTH-1:0] wait_states
);
    localparam int IDX_W = $clog2(DEPTH);
    localparam int WW = axi_mem_pkg::WAIT_WIDTH;

    logic [axi_mem_pkg::DATA_WIDTH-1:0] mem [DEPTH];
    logic                               busy;
    logic                               pending;     // counting wait states
    logic [WW-1:0]                      cnt;
    logic                               is_write;    // kind of the pending access
    logic [axi_mem_pkg::ID_WIDTH-1:0]   resp_id;
    logic [axi_mem_pkg::DATA_WIDTH-1:0] rdata;
    logic                               ar_acc;
    logic                               aw_acc;
    logic                               acc;
    logic                               fire;        // response valid rises next edge
    logic                               resp_write;
    logic [IDX_W-1:0]                   ar_idx;
    logic [IDX_W-1:0]                   aw_idx;

    // busy from accept until the response cycle is over
    assign busy = pending | rvalid | bvalid;
    assign arready = ~busy;
    assign awready = awvalid & wvalid & ~busy & ~arvalid;  // read first on a tie
    assign wready = awready;

    assign ar_acc = arvalid & arready;
    assign aw_acc = awvalid & awready;  // W transfers on the same edge
    assign acc = ar_acc | aw_acc;

    // word index, byte address / 4 mod DEPTH
    assign ar_idx = ar.addr[IDX_W+1:2];
    assign aw_idx = aw.addr[IDX_W+1:2];

    // zero wait states answer straight off the accept edge
    assign fire = (acc & (wait_states == '0)) | (pending & (cnt == WW'(1)));
    assign resp_write = acc ? aw_acc : is_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            rvalid <= fire & ~resp_write;  // one cycle only
            bvalid <= fire & resp_write;
            if (acc & (wait_states != '0)) pending <= 1'b1;
            else if (fire) pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (acc) begin
            cnt <= wait_states;
            is_write <= aw_acc;
            resp_id <= aw_acc ? aw.id : ar.id;  // echoed on R or B
        end else if (pending) begin
            cnt <= cnt - 1'b1;
        end
        if (ar_acc) rdata <= mem[ar_idx];  // snapshot, later writes not seen
    end

    // byte lane writes
    always_ff @(posedge clk) begin
        if (aw_acc) begin
            for (int i = 0; i < axi_mem_pkg::STRB_WIDTH; i++) begin
                if (w.strb[i]) mem[aw_idx][8*i +: 8] <= w.data[8*i +: 8];
            end
        end
    end

    assign r = '{id: resp_id, data: rdata, last: rvalid};
    assign b.id = resp_id;

    // master pairs every W beat with its address
    a_w_with_aw: assert property (@(posedge clk) disable iff (rst)
        wvalid |-> awvalid);

    // every accepted address gets its response within the longest wait
    a_resp_follows: assert property (@(posedge clk) disable iff (rst)
        acc |-> ##[1:16] (rvalid || bvalid));

endmodule

/* verilog/mem_ctrl_regs.sv */
`timescale 1ns/1ps

// settings and status beside the master and the memory
module mem_ctrl_regs (
    input  logic clk,
    input  logic rst,

    input  logic                                reg_we,
    input  logic [1:0]                          reg_addr,
    input  logic [axi_mem_pkg::LIMIT_WIDTH-1:0] reg_wdata,
    output logic [axi_mem_pkg::LIMIT_WIDTH-1:0] reg_rdata,

    input  logic                                new_request,  // counted
    input  logic                                stall,        // watchdog pulse
    output logic [axi_mem_pkg::WAIT_WIDTH-1:0]  wait_states,
    output logic [axi_mem_pkg::LIMIT_WIDTH-1:0] stall_limit
);
    localparam int LW = axi_mem_pkg::LIMIT_WIDTH;
    localparam int WW = axi_mem_pkg::WAIT_WIDTH;

    logic          stall_flag;  // sticky
    logic [LW-1:0] req_cnt;     // wraps

    // address 0 and 1 are plain read/write
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_states <= '0;
            stall_limit <= LW'(64);
        end else if (reg_we) begin
            case (reg_addr)
                2'd0: wait_states <= reg_wdata[WW-1:0];
                2'd1: stall_limit <= reg_wdata;
                default: ;  // 2 clears the flag below, 3 is read-only
            endcase
        end
    end

    // a stall in the same cycle beats the clearing write
    always_ff @(posedge clk) begin
        if (rst) stall_flag <= 1'b0;
        else if (stall) stall_flag <= 1'b1;
        else if (reg_we && reg_addr == 2'd2) stall_flag <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst) req_cnt <= '0;
        else if (new_request) req_cnt <= req_cnt + 1'b1;
    end

    always_comb begin
        case (reg_addr)
            2'd0: reg_rdata = LW'(wait_states);
            2'd1: reg_rdata = stall_limit;
            2'd2: reg_rdata = LW'(stall_flag);
            default: reg_rdata = req_cnt;
        endcase
    end

endmodule

/* verilog/axi_mem_subsys.sv */
`timescale 1ns/1ps

// request port -> AXI master -> AXI memory, steered by the control registers
module axi_mem_subsys #(
    parameter int MASTER_ID = 1,
    parameter int MEM_DEPTH = 256
) (
    input  logic clk,
    input  logic rst,

    input  logic                               new_request,
    input  logic                               we,
    input  logic [axi_mem_pkg::ADDR_WIDTH-1:0] addr,
    input  logic [2:0]                         size,
    input  logic [axi_mem_pkg::DATA_WIDTH-1:0] data_in,
    input  logic [axi_mem_pkg::STRB_WIDTH-1:0] wstrb,
    output logic                               ready_out,
    output logic                               valid_out,
    output logic [axi_mem_pkg::DATA_WIDTH-1:0] data_out,

    input  logic                                reg_we,
    input  logic [1:0]                          reg_addr,
    input  logic [axi_mem_pkg::LIMIT_WIDTH-1:0] reg_wdata,
    output logic [axi_mem_pkg::LIMIT_WIDTH-1:0] reg_rdata
);
    axi_mem_pkg::axi_addr_t ar, aw;
    axi_mem_pkg::axi_w_t    w;
    axi_mem_pkg::axi_r_t    r;
    axi_mem_pkg::axi_b_t    b;
    logic arvalid, arready, awvalid, awready, wvalid, wready, rvalid, bvalid;
    logic [axi_mem_pkg::WAIT_WIDTH-1:0]  wait_states;
    logic [axi_mem_pkg::LIMIT_WIDTH-1:0] stall_limit;
    logic                                stall;

    axi_master #(.ID(MASTER_ID)) master0 (
        .clk, .rst,
        .new_request, .we, .addr, .size, .data_in, .wstrb,
        .ready_out, .valid_out, .data_out,
        .ar, .arvalid, .arready, .aw, .awvalid, .awready,
        .w, .wvalid, .wready, .r, .rvalid, .b, .bvalid,
        .stall_limit, .stall
    );

    axi_mem #(.DEPTH(MEM_DEPTH)) mem0 (
        .clk, .rst,
        .ar, .arvalid, .arready, .aw, .awvalid, .awready,
        .w, .wvalid, .wready, .r, .rvalid, .b, .bvalid,
        .wait_states
    );

    mem_ctrl_regs regs0 (
        .clk, .rst,
        .reg_we, .reg_addr, .reg_wdata, .reg_rdata,
        .new_request, .stall,
        .wait_states, .stall_limit
    );

endmodule

/* dv/tb_axi_mem_subsys.sv */
`timescale 1ns/1ps

module tb_axi_mem_subsys;
    localparam int MEM_DEPTH = 256;
    localparam int RST_CYCLES = 5;
    localparam int N_WR = 16;    // full-word write/read pairs
    localparam int N_STRB = 8;   // full write, partial write, read
    localparam int N_WAIT = 10;  // wait-state rounds
    localparam int TXN_MAX = 20; // 2 + 15 waits + drive cycles
    localparam int N_TXN = 1 + 2 * N_WR + 3 * N_STRB + 2 * N_WAIT + 3;
    localparam int LIMIT = 2 * (RST_CYCLES + TXN_MAX * N_TXN + 4 * 40);  // 40 register accesses

    logic clk, rst, new_request, we, ready_out, valid_out, reg_we;
    logic [2:0]  size;
    logic [31:0] addr, data_in, data_out;
    logic [3:0]  wstrb;
    logic [1:0]  reg_addr;
    logic [15:0] reg_wdata, reg_rdata;

    logic [31:0] model [MEM_DEPTH];  // reference word array
    bit          known [MEM_DEPTH];  // word written at least once
    logic [31:0] addr_q [$];
    int errors = 0, checks = 0, n_tests = 0, n_req = 0, cycle_cnt = 0;

    axi_mem_subsys #(.MASTER_ID(1), .MEM_DEPTH(MEM_DEPTH)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= LIMIT) begin
            $display("timeout: run went past %0d cycles without finishing", LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    task automatic flag_error(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors++;
    endtask

    // read completion only while idle again
    a_valid_with_ready: assert property (@(posedge clk) disable iff (rst)
        valid_out |-> ready_out) else flag_error("valid_out without ready_out");

    task automatic write_reg(input logic [1:0] a, input logic [15:0] d);
        @(negedge clk);
        reg_we = 1'b1;
        reg_addr = a;
        reg_wdata = d;
        @(negedge clk);
        reg_we = 1'b0;
    endtask

    task automatic check_reg(input logic [1:0] a, input logic [15:0] exp);
        @(negedge clk);
        reg_addr = a;
        @(negedge clk);  // combinational read, settled by now
        checks++;
        assert (reg_rdata == exp)
            else flag_error($sformatf("reg %0d read %0h, expected %0h", a, reg_rdata, exp));
    endtask

    // one request, latency counted in edges after the request edge
    task automatic run_txn(input logic is_wr, input logic [31:0] a, input logic [31:0] d,
                           input logic [3:0] s, input int wst);
        int idx;
        int cycles;
        idx = int'((a >> 2) % MEM_DEPTH);
        @(negedge clk);
        new_request = 1'b1;
        we = is_wr;
        addr = a;
        data_in = d;
        wstrb = s;
        n_req++;
        @(negedge clk);  // request edge now behind us
        new_request = 1'b0;
        cycles = 0;
        while (!ready_out) begin
            @(negedge clk);
            cycles++;
        end
        checks += 2;
        assert (cycles == 2 + wst)
            else flag_error($sformatf("latency %0d, expected %0d", cycles, 2 + wst));
        assert (valid_out == !is_wr)
            else flag_error($sformatf("valid_out %0b on %s", valid_out, is_wr ? "write" : "read"));
        if (!is_wr && known[idx]) begin
            checks++;
            assert (data_out == model[idx])
                else flag_error($sformatf("addr %h read %h, expected %h", a, data_out, model[idx]));
        end
        if (is_wr) begin
            for (int i = 0; i < 4; i++) begin
                if (s[i]) model[idx][8*i +: 8] = d[8*i +: 8];  // byte merge
            end
            known[idx] = 1'b1;
        end
    endtask

    task automatic close_test(input string name, input int errs_before);
        n_tests++;
        $display("test %-12s done, %0d errors", name, errors - errs_before);
    endtask

    initial begin
        int e0;
        int wst;
        logic [31:0] a;
        void'($urandom(35482));
        rst = 1'b1;
        {new_request, we, reg_we} = '0;
        size = 3'd2;  // 4-byte beats
        {addr, data_in, reg_wdata} = '0;
        wstrb = 4'hf;
        reg_addr = 2'd0;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;

        e0 = errors;  // reset values and bare latency
        checks++;
        assert (ready_out) else flag_error("ready_out low after reset");
        check_reg(2'd0, 16'd0);
        check_reg(2'd1, 16'd64);
        check_reg(2'd2, 16'd0);
        check_reg(2'd3, 16'd0);
        run_txn(1'b0, 32'h0, 32'h0, 4'h0, 0);
        close_test("reset", e0);

        e0 = errors;
        for (int i = 0; i < N_WR; i++) begin
            a = $urandom() & 32'hffff_fffc;  // upper bits exercise the wrap
            addr_q.push_back(a);
            run_txn(1'b1, a, $urandom(), 4'hf, 0);
        end
        foreach (addr_q[i]) run_txn(1'b0, addr_q[i], 32'h0, 4'h0, 0);
        close_test("write_read", e0);

        e0 = errors;
        for (int i = 0; i < N_STRB; i++) begin
            a = $urandom() & 32'hffff_fffc;
            run_txn(1'b1, a, $urandom(), 4'hf, 0);
            run_txn(1'b1, a, $urandom(), 4'($urandom_range(14, 1)), 0);  // partial lanes
            run_txn(1'b0, a, 32'h0, 4'h0, 0);
        end
        close_test("strobes", e0);

        e0 = errors;
        for (int i = 0; i < N_WAIT; i++) begin
            wst = int'($urandom_range(15, 0));
            write_reg(2'd0, 16'(wst));
            a = $urandom() & 32'hffff_fffc;
            run_txn(1'b1, a, $urandom(), 4'hf, wst);  // full word, fresh address may be unset
            run_txn(1'b0, a, 32'h0, 4'h0, wst);
        end
        close_test("wait_states", e0);

        e0 = errors;  // watchdog, limit 3 against a 10-cycle transaction
        write_reg(2'd1, 16'd3);
        check_reg(2'd1, 16'd3);
        write_reg(2'd0, 16'd8);
        run_txn(1'b0, addr_q[0], 32'h0, 4'h0, 8);
        repeat (2) @(negedge clk);  // last stall pulse lands first
        check_reg(2'd2, 16'd1);
        write_reg(2'd2, 16'd0);
        check_reg(2'd2, 16'd0);
        write_reg(2'd1, 16'd64);
        run_txn(1'b0, addr_q[1], 32'h0, 4'h0, 8);
        repeat (2) @(negedge clk);
        check_reg(2'd2, 16'd0);
        write_reg(2'd0, 16'd0);
        close_test("stall", e0);

        e0 = errors;
        check_reg(2'd3, n_req[15:0]);  // wraps at 2^16
        close_test("req_count", e0);

        $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* files.f */
verilog/axi_mem_pkg.sv
verilog/set_clr_reg.sv
verilog/axi_master.sv
verilog/axi_mem.sv
verilog/mem_ctrl_regs.sv
verilog/axi_mem_subsys.sv
dv/tb_axi_mem_subsys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_axi_mem_subsys
FILELIST  := files.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG  := Everything OK
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
